// File: build.f
logic/sync_pkg.sv
logic/sync_cfg_regs.sv
logic/sync_polarity.sv
logic/sync_combine.sv
logic/video_sync_top.sv
test/tb_clock_gen.sv
test/video_sync_checker.sv
test/tb_video_sync.sv

// File: run.sh
#!/bin/sh
# build and run the video sync testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_video_sync -Mdir obj_dir -f build.f > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/Vtb_video_sync +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status, see sim.log"
	exit 1
fi

echo "simulation finished without failure"
exit 0

// File: test/tb_video_sync.sv
/* video sync conditioning testbench */

module tb_video_sync;

	import sync_pkg::*;

	localparam int          PERIOD     = 100;
	localparam int          DRIVE_DLY  = 10;
	localparam logic [31:0] SEED       = 32'h2a2451b2;
	localparam int          NUM_ROUNDS = 6;
	localparam int          MAX_LINE   = 48;
	localparam int          MAX_LINES  = 12;
	localparam longint      WATCHDOG   =
		longint'(NUM_ROUNDS * 4 * MAX_LINE * MAX_LINES + 1000) * PERIOD * 2;
	localparam logic [SYNC_CNT_W-1:0] CNT_MAX = '1;

	logic                  clk_sys;
	logic                  resetd;
	logic                  i_psel;
	logic                  i_penable;
	logic                  i_pwrite;
	logic [APB_ADDR_W-1:0] i_paddr;
	logic [APB_DATA_W-1:0] i_pwdata;
	logic [APB_DATA_W-1:0] o_prdata;
	logic                  o_pready;
	logic                  o_pslverr;
	logic                  i_hs_raw;
	logic                  i_vs_raw;
	logic                  o_hs;
	logic                  o_vs;
	logic                  o_cs;

	// sync source state
	int   src_line;
	int   src_hw;
	int   src_lines;
	int   src_vw;
	int   src_hc;
	int   src_lc;
	logic src_run;
	logic hs_low;
	logic vs_low;
	logic hs_act;
	logic vs_act;

	// reference model with index 0 for hs and 1 for vs
	logic                  p_s1[2];
	logic                  p_s2[2];
	logic                  p_pol[2];
	logic [SYNC_CNT_W-1:0] p_run[2];
	logic [SYNC_CNT_W-1:0] p_hi[2];
	logic [SYNC_CNT_W-1:0] p_lo[2];
	logic                  c_hs_r;
	logic                  c_vs_r;
	logic                  c_csync;
	logic                  c_en;
	logic                  c_ohs;
	logic                  c_ovs;
	logic                  c_ocs;
	logic [SYNC_CNT_W-1:0] c_cnt;
	logic [SYNC_CNT_W-1:0] c_hlen;
	logic [SYNC_CNT_W-1:0] c_llen;
	logic [1:0]            d1;
	logic [1:0]            d2;
	logic                  delay_chk;
	logic                  rnd_csync;
	logic [31:0]           rng;

	tb_clock_gen #(.PERIOD(PERIOD)) u_clk (.o_clk(clk_sys));

	video_sync_top video_sync_top_i (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.i_hs_raw  (i_hs_raw),
		.i_vs_raw  (i_vs_raw),
		.o_hs      (o_hs),
		.o_vs      (o_vs),
		.o_cs      (o_cs)
	);

	bind sync_cfg_regs video_sync_checker #(.CHK_APB(1'b1), .CHK_VS(1'b0)) u_regs_chk (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pready  (o_pready),
		.i_pslverr (o_pslverr),
		.i_vs_norm (1'b0),
		.i_vs_out  (1'b0)
	);

	bind sync_combine video_sync_checker #(.CHK_APB(1'b0), .CHK_VS(1'b1)) u_comb_chk (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_psel    (1'b0),
		.i_penable (1'b0),
		.i_pready  (1'b1),
		.i_pslverr (1'b0),
		.i_vs_norm (i_vs),
		.i_vs_out  (o_vs)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int pick(input int lo, input int hi);
		rng = xorshift32(rng);
		return lo + int'(rng % (hi - lo + 1));
	endfunction

	function automatic int unsigned assert_fails();
		return video_sync_top_i.u_cfg_regs.u_regs_chk.fail_cnt
			+ video_sync_top_i.u_combine.u_comb_chk.fail_cnt;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s dut=0x%08h exp=0x%08h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#(DRIVE_DLY);
	endtask

	task automatic run_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	// one zero wait APB transfer with setup and access phases
	task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
			input logic [APB_DATA_W-1:0] wdata, output logic [APB_DATA_W-1:0] rdata,
			output logic err);
		i_psel    = 1'b1;
		i_penable = 1'b0;
		i_pwrite  = write;
		i_paddr   = addr;
		i_pwdata  = wdata;
		next_cycle();
		i_penable = 1'b1;
		@(negedge clk_sys);
		check_eq("o_pready", o_pready, 1);
		rdata = o_prdata;
		err   = o_pslverr;
		next_cycle();
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	task automatic reset_model();
		for (int k = 0; k < 2; k++) begin
			p_s1[k]  = 1'b0;
			p_s2[k]  = 1'b0;
			p_pol[k] = 1'b0;
			p_run[k] = '0;
			p_hi[k]  = '0;
			p_lo[k]  = '0;
		end
		{c_hs_r, c_vs_r, c_csync, c_en, c_ohs, c_ovs, c_ocs} = '0;
		c_cnt  = '0;
		c_hlen = '0;
		c_llen = '0;
	endtask

	// polarity rule for one sync
	// norm uses the flag from before this edge
	task automatic step_detector(input int k, input logic raw, output logic norm);
		logic pol_next;
		norm     = raw ^ p_pol[k];
		pol_next = p_hi[k] > p_lo[k];
		if (p_s1[k] && !p_s2[k])
			p_lo[k] = p_run[k];
		if (!p_s1[k] && p_s2[k])
			p_hi[k] = p_run[k];
		if (p_s1[k] != p_s2[k])
			p_run[k] = '0;
		else if (p_run[k] != CNT_MAX)
			p_run[k] = p_run[k] + 1'b1;
		p_s2[k]  = p_s1[k];
		p_s1[k]  = raw;
		p_pol[k] = pol_next;
	endtask

	always @(posedge clk_sys) begin
		logic hs_n;
		logic vs_n;
		logic rise;
		logic fall;
		logic cs_now;
		if (resetd) begin
			reset_model();
		end else begin
			step_detector(0, i_hs_raw, hs_n);
			step_detector(1, i_vs_raw, vs_n);
			rise   = hs_n & ~c_hs_r;
			fall   = ~hs_n & c_hs_r;
			cs_now = c_vs_r ^ c_csync;
			c_ohs  = c_en ? cs_now : c_hs_r;
			c_ovs  = c_vs_r;
			c_ocs  = cs_now;
			// composite hs with the pulse moved by one line in vsync
			if (!vs_n)
				c_csync = hs_n;
			else if (c_cnt == c_llen)
				c_csync = 1'b1;
			else if (rise)
				c_csync = 1'b0;
			if (rise)
				c_llen = c_cnt - c_hlen;
			if (fall)
				c_hlen = c_cnt;
			if (rise || fall)
				c_cnt = '0;
			else if (c_cnt != CNT_MAX)
				c_cnt = c_cnt + 1'b1;
			c_hs_r = hs_n;
			c_vs_r = vs_n;
			if (i_psel && i_penable && i_pwrite && i_paddr == REG_CTRL)
				c_en = i_pwdata[CTRL_CSYNC_EN];
		end
		// active-high syncs seen at the last two edges
		d2 = d1;
		d1 = {vs_act, hs_act};
	end

	always @(negedge clk_sys) begin
		if (!resetd) begin
			check_eq("o_hs", o_hs, c_ohs);
			check_eq("o_vs", o_vs, c_ovs);
			check_eq("o_cs", o_cs, c_ocs);
			if (delay_chk) begin
				check_eq("o_vs vs delayed raw vs", o_vs, d2[1]);
				if (!rnd_csync)
					check_eq("o_hs vs delayed raw hs", o_hs, d2[0]);
			end
			if (assert_fails() != 0) begin
				$display("a bound assertion on the DUT failed");
				$display("TB FAILED");
				$fatal(1, "stopped on assertion failure");
			end
		end
	end

	////////////////////////////////////////////////////////////
	// sync source and test sequence
	////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		#(DRIVE_DLY);
		if (src_run) begin
			hs_act   = (src_hc < src_hw);
			vs_act   = (src_lc < src_vw);
			i_hs_raw = hs_act ^ hs_low;
			i_vs_raw = vs_act ^ vs_low;
			if (src_hc == src_line - 1) begin
				src_hc = 0;
				src_lc = (src_lc == src_lines - 1) ? 0 : src_lc + 1;
			end else begin
				src_hc = src_hc + 1;
			end
		end
	end

	initial begin
		logic [31:0]           rdata;
		logic [31:0]           wval;
		logic [31:0]           exp_ctrl;
		logic                  err;
		logic [APB_ADDR_W-1:0] addr;
		int                    frame;
		int                    r;
		rng       = SEED;
		resetd    = 1'b1;
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
		i_paddr   = '0;
		i_pwdata  = '0;
		i_hs_raw  = 1'b0;
		i_vs_raw  = 1'b0;
		{src_run, hs_low, vs_low, hs_act, vs_act, delay_chk, rnd_csync} = '0;
		repeat (3) @(posedge clk_sys);
		#(DRIVE_DLY);
		resetd = 1'b0;

		@(negedge clk_sys);
		check_eq("o_hs", o_hs, 0);
		check_eq("o_vs", o_vs, 0);
		check_eq("o_cs", o_cs, 0);
		next_cycle();
		apb_access(1'b0, REG_CTRL, '0, rdata, err);
		check_eq("o_pslverr", err, 0);
		check_eq("o_prdata ctrl", rdata, 0);
		apb_access(1'b0, REG_STATUS, '0, rdata, err);
		check_eq("o_pslverr", err, 0);
		check_eq("o_prdata status", rdata, 0);

		// control readback and error responses
		repeat (4) begin
			rng      = xorshift32(rng);
			wval     = rng;
			exp_ctrl = 32'(wval[CTRL_CSYNC_EN]) << CTRL_CSYNC_EN;
			apb_access(1'b1, REG_CTRL, wval, rdata, err);
			check_eq("o_pslverr", err, 0);
			apb_access(1'b0, REG_CTRL, '0, rdata, err);
			check_eq("o_prdata ctrl", rdata, exp_ctrl);
			addr = 4'(pick(1, 15));
			if (addr == REG_STATUS)
				addr = 4'hc;
			apb_access(1'b1, addr, ~wval, rdata, err);
			check_eq("o_pslverr", err, 1);
			apb_access(1'b0, addr, '0, rdata, err);
			check_eq("o_pslverr", err, 1);
			check_eq("o_prdata unmapped", rdata, 0);
			apb_access(1'b1, REG_STATUS, ~wval, rdata, err);
			check_eq("o_pslverr", err, 1);
			apb_access(1'b0, REG_CTRL, '0, rdata, err);
			check_eq("o_prdata ctrl", rdata, exp_ctrl);
		end

		for (r = 0; r < NUM_ROUNDS; r++) begin
			@(negedge clk_sys);
			src_line  = pick(24, MAX_LINE);
			src_hw    = pick(3, 7);
			src_lines = pick(8, MAX_LINES);
			src_vw    = pick(2, 3);
			hs_low    = 1'(pick(0, 1));
			vs_low    = 1'(pick(0, 1));
			rnd_csync = (r < 2) ? 1'(r) : 1'(pick(0, 1));
			src_hc    = 0;
			src_lc    = 0;
			src_run   = 1'b1;
			frame     = src_line * src_lines;
			next_cycle();
			apb_access(1'b1, REG_CTRL, 32'(rnd_csync) << CTRL_CSYNC_EN, rdata, err);
			check_eq("o_pslverr", err, 0);
			// two complete frames let both detectors settle
			run_cycles(2 * frame);
			apb_access(1'b0, REG_STATUS, '0, rdata, err);
			check_eq("o_pslverr", err, 0);
			check_eq("o_prdata status", rdata,
				(32'(hs_low) << STAT_HS_POL) | (32'(vs_low) << STAT_VS_POL));
			delay_chk = 1'b1;
			run_cycles(2 * frame);
			delay_chk = 1'b0;
		end

		if (assert_fails() != 0) begin
			$display("bound assertions failed %0d times", assert_fails());
			$display("TB FAILED");
			$fatal(1, "assertion failures at end of run");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG);
		$display("timeout, the test sequence did not finish in time");
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: test/video_sync_checker.sv
/* bound sync assertions */

module video_sync_checker #(
	parameter bit CHK_APB = 1'b1,
	parameter bit CHK_VS  = 1'b1
) (
	input logic clk_sys,
	input logic resetd,
	input logic i_psel,
	input logic i_penable,
	input logic i_pready,
	input logic i_pslverr,
	input logic i_vs_norm,
	input logic i_vs_out
);

	// number of failed assertions
	int unsigned fail_cnt = 0;

	if (CHK_APB) begin : g_apb
		// zero wait state slave
		a_pready: assert property (@(posedge clk_sys) disable iff (resetd) i_pready)
			else begin
				fail_cnt++;
				$error("pready went low");
			end

		a_pslverr_idle: assert property (@(posedge clk_sys) disable iff (resetd)
			!(i_psel && i_penable) |-> !i_pslverr)
			else begin
				fail_cnt++;
				$error("pslverr high outside an access phase");
			end
	end

	if (CHK_VS) begin : g_vs
		// two register stages from normalized vs to the pin
		a_vs_delay: assert property (@(posedge clk_sys) disable iff (resetd)
			i_vs_out == $past(i_vs_norm, 2))
			else begin
				fail_cnt++;
				$error("o_vs is not the normalized vs delayed by two cycles");
			end
	end

endmodule

// File: test/tb_clock_gen.sv
/* testbench clock */

module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic o_clk
);

	initial o_clk = 1'b0;

	always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// File: logic/video_sync_top.sv
/* video sync conditioning top */

module video_sync_top (
	input  logic                            clk_sys,
	input  logic                            resetd,
	input  logic                            i_psel,
	input  logic                            i_penable,
	input  logic                            i_pwrite,
	input  logic [sync_pkg::APB_ADDR_W-1:0] i_paddr,
	input  logic [sync_pkg::APB_DATA_W-1:0] i_pwdata,
	output logic [sync_pkg::APB_DATA_W-1:0] o_prdata,
	output logic                            o_pready,
	output logic                            o_pslverr,
	input  logic                            i_hs_raw,
	input  logic                            i_vs_raw,
	output logic                            o_hs,
	output logic                            o_vs,
	output logic                            o_cs
);

	logic hs_norm;
	logic vs_norm;
	logic hs_pol;
	logic vs_pol;
	logic csync_en;

	// host register block
	sync_cfg_regs u_cfg_regs (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_psel     (i_psel),
		.i_penable  (i_penable),
		.i_pwrite   (i_pwrite),
		.i_paddr    (i_paddr),
		.i_pwdata   (i_pwdata),
		.o_prdata   (o_prdata),
		.o_pready   (o_pready),
		.o_pslverr  (o_pslverr),
		.i_hs_pol   (hs_pol),
		.i_vs_pol   (vs_pol),
		.o_csync_en (csync_en)
	);

	// one detector per sync
	sync_polarity u_hs_pol (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_sync_raw (i_hs_raw),
		.o_sync     (hs_norm),
		.o_pol      (hs_pol)
	);

	sync_polarity u_vs_pol (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_sync_raw (i_vs_raw),
		.o_sync     (vs_norm),
		.o_pol      (vs_pol)
	);

	sync_combine u_combine (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_hs       (hs_norm),
		.i_vs       (vs_norm),
		.i_csync_en (csync_en),
		.o_hs       (o_hs),
		.o_vs       (o_vs),
		.o_cs       (o_cs)
	);

endmodule

// File: logic/sync_combine.sv
/* composite sync and output stage */

module sync_combine (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	input  logic i_csync_en,
	output logic o_hs,
	output logic o_vs,
	output logic o_cs
);

	import sync_pkg::*;

	logic                  hs_r;
	logic                  vs_r;
	logic                  hs_rise;
	logic                  hs_fall;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] hs_len;
	logic [SYNC_CNT_W-1:0] line_len;
	logic                  csync_hs;
	logic                  cs;

	// hs_r also serves as the previous hs for edge detection
	assign hs_rise = i_hs & ~hs_r;
	assign hs_fall = ~i_hs & hs_r;

	////////////////////////////////////////////////////////////
	// first stage, line measurement and composite hs
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_r     <= 1'b0;
			vs_r     <= 1'b0;
			h_cnt    <= '0;
			hs_len   <= '0;
			line_len <= '0;
			csync_hs <= 1'b0;
		end else begin
			hs_r <= i_hs;
			vs_r <= i_vs;

			// cycles since the last hs edge
			if (hs_rise || hs_fall) begin
				h_cnt <= '0;
			end else if (h_cnt != '1) begin
				h_cnt <= h_cnt + 1'b1;
			end

			if (hs_rise) begin
				line_len <= h_cnt - hs_len;
			end
			if (hs_fall) begin
				hs_len <= h_cnt;
			end

			// during vsync the pulse moves one line length later
			if (!i_vs) begin
				csync_hs <= i_hs;
			end else if (h_cnt == line_len) begin
				csync_hs <= 1'b1;
			end else if (hs_rise) begin
				csync_hs <= 1'b0;
			end
		end
	end

	assign cs = vs_r ^ csync_hs;

	////////////////////////////////////////////////////////////
	// second stage, registered outputs
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_hs <= 1'b0;
			o_vs <= 1'b0;
			o_cs <= 1'b0;
		end else begin
			o_hs <= i_csync_en ? cs : hs_r;
			o_vs <= vs_r;
			o_cs <= cs;
		end
	end

endmodule

// File: logic/sync_polarity.sv
/* sync polarity detector */

module sync_polarity (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync_raw,
	output logic o_sync,
	output logic o_pol
);

	import sync_pkg::*;

	logic                  s1;
	logic                  s2;
	logic [SYNC_CNT_W-1:0] run_cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;
	logic                  pol;

	// sample the raw sync and measure each run
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync_raw;
			s2 <= s1;

			// rising edge ends a low run, falling edge a high run
			if (s1 && !s2) begin
				low_len <= run_cnt;
			end
			if (!s1 && s2) begin
				high_len <= run_cnt;
			end

			if (s1 != s2) begin
				run_cnt <= '0;
			end else if (run_cnt != '1) begin
				run_cnt <= run_cnt + 1'b1;
			end

			// the sync pulse is the shorter run
			pol <= (high_len > low_len);
		end
	end

	assign o_sync = i_sync_raw ^ pol;
	assign o_pol  = pol;

endmodule

// File: logic/sync_cfg_regs.sv
/* sync control and status registers */

module sync_cfg_regs (
	input  logic                            clk_sys,
	input  logic                            resetd,
	input  logic                            i_psel,
	input  logic                            i_penable,
	input  logic                            i_pwrite,
	input  logic [sync_pkg::APB_ADDR_W-1:0] i_paddr,
	input  logic [sync_pkg::APB_DATA_W-1:0] i_pwdata,
	output logic [sync_pkg::APB_DATA_W-1:0] o_prdata,
	output logic                            o_pready,
	output logic                            o_pslverr,
	input  logic                            i_hs_pol,
	input  logic                            i_vs_pol,
	output logic                            o_csync_en
);

	import sync_pkg::*;

	logic access;
	logic hit_ctrl;
	logic hit_status;
	logic acc_err;
	logic csync_en;

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	assign access     = i_psel & i_penable;
	assign hit_ctrl   = (i_paddr == REG_CTRL);
	assign hit_status = (i_paddr == REG_STATUS);

	// unmapped address, or a write to the read-only status
	assign acc_err = access & (~(hit_ctrl | hit_status) | (i_pwrite & hit_status));

	// zero wait state slave
	assign o_pready  = 1'b1;
	assign o_pslverr = acc_err;

	////////////////////////////////////////////////////////////
	// control register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			csync_en <= 1'b0;
		end else if (access && i_pwrite && hit_ctrl) begin
			csync_en <= i_pwdata[CTRL_CSYNC_EN];
		end
	end

	assign o_csync_en = csync_en;

	////////////////////////////////////////////////////////////
	// read mux
	////////////////////////////////////////////////////////////

	always_comb begin
		o_prdata = '0;
		if (!acc_err) begin
			if (hit_ctrl) begin
				o_prdata[CTRL_CSYNC_EN] = csync_en;
			end else if (hit_status) begin
				// polarity flags straight from the detectors
				o_prdata[STAT_HS_POL] = i_hs_pol;
				o_prdata[STAT_VS_POL] = i_vs_pol;
			end
		end
	end

endmodule

// File: logic/sync_pkg.sv
/* video sync conditioning definitions */

package sync_pkg;

	////////////////////////////////////////////////////////////
	// counter widths
	////////////////////////////////////////////////////////////

	// run-length and line-length counters saturate at all ones
	localparam int SYNC_CNT_W = 16;

	////////////////////////////////////////////////////////////
	// APB register map
	////////////////////////////////////////////////////////////

	localparam int APB_ADDR_W = 4;
	localparam int APB_DATA_W = 32;

	localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 4'h0;
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'h4;

	// control bits
	localparam int CTRL_CSYNC_EN = 0;

	// status bits, set when the raw sync is active low
	localparam int STAT_HS_POL = 0;
	localparam int STAT_VS_POL = 1;

endpackage
